/* vlog.f */
audio_pkg.sv
audio_cmd_decoder.sv
audio_crossfeed.sv
audio_volume.sv
audio_out_format.sv
audio_post_top.sv
audio_post_props.sv
tb_audio_post.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the audio post-processing testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

TOP=tb_audio_post
OBJ=obj_dir

verilator --binary --timing --assert \
	--top-module "$TOP" \
	--Mdir "$OBJ" \
	-f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

OUT=$("./$OBJ/V$TOP" 2>&1)
STATUS=$?
echo "$OUT"

if [ $STATUS -ne 0 ]; then
	echo "Simulation exited with status $STATUS"
	exit 1
fi

if echo "$OUT" | grep -qF "ALL CHECKS PASSED"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi

/* tb_audio_post.sv */
// Audio post-processing testbench

`timescale 1ns/1ps

module tb_audio_post;

	localparam int SHIFT_BITS = 4;
	localparam int unsigned SEED = 32'h7957;
	localparam int N_SAMPLES = 320;
	localparam int N_WORDS = 13;
	localparam int TIMEOUT_CYCLES = 4 * (N_SAMPLES + N_WORDS) + 200;

	logic                  clk_sys = 1'b0;
	logic                  resetd;
	audio_pkg::audio_in_t  i_in;
	logic                  i_in_valid;
	logic                  o_in_ready;
	logic                  i_io_uio;
	logic                  i_io_strobe;
	audio_pkg::io_word_t   i_io_din;
	audio_pkg::audio_out_t o_out;
	logic                  o_out_valid;
	logic                  i_out_ready = 1'b1;

	audio_pkg::vol_att_t   cur_att;
	audio_pkg::audio_out_t exp_q[$];
	int                    acc_q[$];
	int                    cycle_cnt = 0;
	logic                  check_latency;
	logic                  stall_mode;
	logic                  gaps;

	audio_post_top #(
		.SHIFT_BITS(SHIFT_BITS)
	) uut (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_in       (i_in),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_out      (o_out),
		.o_out_valid(o_out_valid),
		.i_out_ready(i_out_ready)
	);

	always #10 clk_sys = ~clk_sys;

	// ====================
	// Reference model
	// ====================

	// Floor division by 2^n for signed data, plain division otherwise
	function automatic audio_pkg::sample_t shift_down(
		input audio_pkg::sample_t v,
		input int                 n,
		input logic               sgn
	);
		int x;
		if (sgn)
			x = int'($signed(v));
		else
			x = int'(v);
		return audio_pkg::sample_t'(x >>> n);
	endfunction

	function automatic audio_pkg::sample_t mix_one(
		input audio_pkg::sample_t   own,
		input audio_pkg::sample_t   other,
		input audio_pkg::mix_mode_t mode,
		input logic                 sgn
	);
		int f;
		f = (mode == 2'd1) ? 3 : 2;
		case (mode)
			2'd0:    return own;
			2'd3:    return shift_down(own, 1, sgn) + shift_down(other, 1, sgn);
			default: return own - shift_down(own, f, sgn) + shift_down(other, f, sgn);
		endcase
	endfunction

	function automatic audio_pkg::audio_out_t ref_audio(
		input audio_pkg::audio_in_t s,
		input audio_pkg::vol_att_t  att
	);
		audio_pkg::sample_t    l;
		audio_pkg::sample_t    r;
		audio_pkg::audio_out_t o;
		l = mix_one(s.left, s.right, s.mix, s.is_signed);
		r = mix_one(s.right, s.left, s.mix, s.is_signed);
		if (att[audio_pkg::VOL_MUTE_BIT]) begin
			l = '0;
			r = '0;
		end else begin
			l = shift_down(l, int'(att[3:0]), s.is_signed);
			r = shift_down(r, int'(att[3:0]), s.is_signed);
		end
		o.pcm_l = s.is_signed ? l : {1'b0, l[15:1]};
		o.pcm_r = s.is_signed ? r : {1'b0, r[15:1]};
		o.dac_l = s.is_signed ? (l ^ 16'h8000) : l;
		o.dac_r = s.is_signed ? (r ^ 16'h8000) : r;
		return o;
	endfunction

	task automatic check_value(
		input string       name,
		input logic [15:0] got,
		input logic [15:0] want
	);
		if (got !== want) begin
			$display("[ERROR] t=%0t %s got 16'h%04h expected 16'h%04h", $time, name, got, want);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// ====================
	// Monitors
	// ====================

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run hung: no progress within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	// Expected result for every accepted sample
	always @(posedge clk_sys) begin
		if (!resetd && i_in_valid && o_in_ready) begin
			exp_q.push_back(ref_audio(i_in, cur_att));
			acc_q.push_back(cycle_cnt);
		end
	end

	always @(posedge clk_sys) begin
		audio_pkg::audio_out_t want;
		int                    acc;
		if (!resetd && o_out_valid && i_out_ready) begin
			if (exp_q.size() == 0) begin
				$display("Output transfer at %0t without a sample sent", $time);
				$display("CHECKS FAILED");
				$fatal(1, "unexpected output");
			end else begin
				want = exp_q.pop_front();
				acc = acc_q.pop_front();
				check_value("o_out.pcm_l", o_out.pcm_l, want.pcm_l);
				check_value("o_out.pcm_r", o_out.pcm_r, want.pcm_r);
				check_value("o_out.dac_l", o_out.dac_l, want.dac_l);
				check_value("o_out.dac_r", o_out.dac_r, want.dac_r);
				if (check_latency)
					check_value("o_out_valid latency", 16'(cycle_cnt - acc), 16'd3);
			end
		end
	end

	// Random back-pressure only in the stall phase
	always @(negedge clk_sys) begin
		logic [31:0] r;
		r = $urandom();
		i_out_ready <= stall_mode ? r[0] : 1'b1;
	end

	// ====================
	// Stimulus
	// ====================

	task automatic send_sample(input logic sgn, input audio_pkg::mix_mode_t mode);
		logic [31:0] ra;
		logic [31:0] rb;
		ra = $urandom();
		rb = $urandom();
		if (gaps)
			repeat (int'(rb[17:16])) @(negedge clk_sys);
		i_in.left = ra[15:0];
		i_in.right = rb[15:0];
		i_in.is_signed = sgn;
		i_in.mix = mode;
		i_in_valid = 1'b1;
		do begin
			@(posedge clk_sys);
		end while (!o_in_ready);
		@(negedge clk_sys);
		i_in_valid = 1'b0;
	endtask

	task automatic send_batch(input int n, input logic any_mode);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = $urandom();
			send_sample(r[2], any_mode ? r[1:0] : 2'd0);
		end
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(negedge clk_sys);
	endtask

	// Only with the pipeline empty, so every sample sees one setting
	task automatic send_frame(
		input audio_pkg::io_word_t code_word,
		input logic                with_data,
		input audio_pkg::io_word_t data_word
	);
		wait_drained();
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		@(negedge clk_sys);
		i_io_din = code_word;
		i_io_strobe = 1'b1;
		// Strobe held two cycles for one word
		repeat (2) @(negedge clk_sys);
		i_io_strobe = 1'b0;
		if (with_data) begin
			@(negedge clk_sys);
			i_io_din = data_word;
			i_io_strobe = 1'b1;
			@(negedge clk_sys);
			i_io_strobe = 1'b0;
		end
		@(negedge clk_sys);
		i_io_uio = 1'b0;
		@(negedge clk_sys);
		if (with_data && code_word[7:0] == audio_pkg::CMD_VOLUME)
			cur_att = {data_word[4], data_word[3:0]};
	endtask

	initial begin
		void'($urandom(SEED));
		resetd = 1'b1;
		i_in = '0;
		i_in_valid = 1'b0;
		i_io_uio = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din = '0;
		cur_att = '0;
		check_latency = 1'b0;
		stall_mode = 1'b0;
		gaps = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;

		// No mixing, no attenuation, fixed latency
		check_latency = 1'b1;
		send_batch(40, 1'b0);
		wait_drained();
		check_latency = 1'b0;
		send_batch(80, 1'b1);

		// Shift values, then mute
		send_frame(16'h0026, 1'b1, 16'h0001);
		send_batch(20, 1'b1);
		send_frame(16'h0026, 1'b1, 16'h0005);
		send_batch(20, 1'b1);
		send_frame(16'h0026, 1'b1, 16'h000f);
		send_batch(20, 1'b1);
		send_frame(16'h0026, 1'b1, 16'h0010);
		send_batch(20, 1'b1);
		send_frame(16'h0026, 1'b1, 16'h0002);

		// Random stalls and input gaps
		stall_mode = 1'b1;
		gaps = 1'b1;
		send_batch(100, 1'b1);
		wait_drained();
		stall_mode = 1'b0;
		gaps = 1'b0;

		// Foreign code and a bare command word leave shift 2 in place
		send_frame(16'h0011, 1'b1, 16'h0013);
		send_frame(16'h0026, 1'b0, 16'h0000);
		send_batch(20, 1'b1);
		wait_drained();
		repeat (5) @(negedge clk_sys);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* audio_post_props.sv */
// Audio pipeline assertions

`timescale 1ns/1ps

module audio_post_props (
	input logic                  clk_sys,
	input logic                  resetd,
	input audio_pkg::vol_att_t   i_vol_att,
	input logic                  i_xf_valid,
	input logic                  i_vol_ready,
	input logic                  i_vol_valid,
	input logic                  i_fmt_ready,
	input audio_pkg::audio_mid_t i_vol_out,
	input audio_pkg::audio_out_t i_out,
	input logic                  i_out_valid,
	input logic                  i_out_ready
);

	// Stalled output holds
	out_stall_stable: assert property (@(posedge clk_sys) disable iff (resetd)
		i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out))
		else $error("output changed while stalled");

	// All stage registers empty after reset
	reset_empty: assert property (@(posedge clk_sys)
		resetd |=> !i_out_valid && !i_xf_valid && !i_vol_valid)
		else $error("stage valid high after reset");

	mute_zero: assert property (@(posedge clk_sys) disable iff (resetd)
		i_xf_valid && i_vol_ready && i_vol_att[audio_pkg::VOL_MUTE_BIT]
		|=> i_vol_out.left == '0 && i_vol_out.right == '0)
		else $error("muted sample not zero");

	// Zero signed channels give zero PCM words
	zero_pcm: assert property (@(posedge clk_sys) disable iff (resetd)
		i_vol_valid && i_fmt_ready && i_vol_out.is_signed
		&& i_vol_out.left == '0 && i_vol_out.right == '0
		|=> i_out.pcm_l == '0 && i_out.pcm_r == '0)
		else $error("zero sample gave nonzero PCM word");

endmodule

bind audio_post_top audio_post_props u_props (
	.clk_sys    (clk_sys),
	.resetd     (resetd),
	.i_vol_att  (vol_att),
	.i_xf_valid (xf_valid),
	.i_vol_ready(vol_ready),
	.i_vol_valid(vol_valid),
	.i_fmt_ready(fmt_ready),
	.i_vol_out  (vol_out),
	.i_out      (o_out),
	.i_out_valid(o_out_valid),
	.i_out_ready(i_out_ready)
);

/* audio_post_top.sv */
// Audio post-processing top level

`timescale 1ns/1ps

module audio_post_top #(
	parameter int SHIFT_BITS = 4
) (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  audio_pkg::audio_in_t  i_in,
	input  logic                  i_in_valid,
	output logic                  o_in_ready,
	input  logic                  i_io_uio,
	input  logic                  i_io_strobe,
	input  audio_pkg::io_word_t   i_io_din,
	output audio_pkg::audio_out_t o_out,
	output logic                  o_out_valid,
	input  logic                  i_out_ready
);

	audio_pkg::vol_att_t   vol_att;
	audio_pkg::audio_mid_t xf_out;
	logic                  xf_valid;
	logic                  vol_ready;
	audio_pkg::audio_mid_t vol_out;
	logic                  vol_valid;
	logic                  fmt_ready;

	// Side block, sets the volume level
	audio_cmd_decoder #(
		.SHIFT_BITS(SHIFT_BITS)
	) u_cmd (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_vol_att  (vol_att)
	);

	// ====================
	// Sample pipeline
	// ====================

	audio_crossfeed u_xfeed (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_in   (i_in),
		.i_valid(i_in_valid),
		.o_ready(o_in_ready),
		.o_out  (xf_out),
		.o_valid(xf_valid),
		.i_ready(vol_ready)
	);

	audio_volume #(
		.SHIFT_BITS(SHIFT_BITS)
	) u_vol (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_vol_att(vol_att),
		.i_in     (xf_out),
		.i_valid  (xf_valid),
		.o_ready  (vol_ready),
		.o_out    (vol_out),
		.o_valid  (vol_valid),
		.i_ready  (fmt_ready)
	);

	audio_out_format u_fmt (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_in   (vol_out),
		.i_valid(vol_valid),
		.o_ready(fmt_ready),
		.o_out  (o_out),
		.o_valid(o_out_valid),
		.i_ready(i_out_ready)
	);

endmodule

/* audio_out_format.sv */
// PCM and DAC output formatting stage

`timescale 1ns/1ps

module audio_out_format (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  audio_pkg::audio_mid_t i_in,
	input  logic                  i_valid,
	output logic                  o_ready,
	output audio_pkg::audio_out_t o_out,
	output logic                  o_valid,
	input  logic                  i_ready
);

	audio_pkg::audio_out_t fmt;

	always_comb begin
		// Unsigned data halved to fit the positive PCM range
		fmt.pcm_l = i_in.is_signed ? i_in.left : i_in.left >> 1;
		fmt.pcm_r = i_in.is_signed ? i_in.right : i_in.right >> 1;
		// Signed data moved to offset binary for the DAC
		fmt.dac_l = i_in.is_signed ? {~i_in.left[15], i_in.left[14:0]} : i_in.left;
		fmt.dac_r = i_in.is_signed ? {~i_in.right[15], i_in.right[14:0]} : i_in.right;
	end

	// ====================
	// Output register
	// ====================

	assign o_ready = ~o_valid | i_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			o_valid <= 1'b0;
		else if (o_ready)
			o_valid <= i_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (i_valid && o_ready)
			o_out <= fmt;
	end

endmodule

/* audio_volume.sv */
// Volume attenuation stage

`timescale 1ns/1ps

module audio_volume #(
	parameter int SHIFT_BITS = 4
) (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  audio_pkg::vol_att_t   i_vol_att,
	input  audio_pkg::audio_mid_t i_in,
	input  logic                  i_valid,
	output logic                  o_ready,
	output audio_pkg::audio_mid_t o_out,
	output logic                  o_valid,
	input  logic                  i_ready
);

	logic                  mute;
	logic [SHIFT_BITS-1:0] shift;
	audio_pkg::audio_mid_t scaled;

	assign mute  = i_vol_att[audio_pkg::VOL_MUTE_BIT];
	assign shift = i_vol_att[SHIFT_BITS-1:0];

	always_comb begin
		scaled.is_signed = i_in.is_signed;
		if (mute) begin
			scaled.left  = '0;
			scaled.right = '0;
		end else if (i_in.is_signed) begin
			// Keep the sign on the way down
			scaled.left  = audio_pkg::sample_t'($signed(i_in.left) >>> shift);
			scaled.right = audio_pkg::sample_t'($signed(i_in.right) >>> shift);
		end else begin
			scaled.left  = i_in.left >> shift;
			scaled.right = i_in.right >> shift;
		end
	end

	// ====================
	// Output register
	// ====================

	assign o_ready = ~o_valid | i_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			o_valid <= 1'b0;
		else if (o_ready)
			o_valid <= i_valid;
	end

	// Setting is sampled with the sample it applies to
	always_ff @(posedge clk_sys) begin
		if (i_valid && o_ready)
			o_out <= scaled;
	end

endmodule

/* audio_crossfeed.sv */
// Stereo crossfeed mixing stage

`timescale 1ns/1ps

module audio_crossfeed (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  audio_pkg::audio_in_t  i_in,
	input  logic                  i_valid,
	output logic                  o_ready,
	output audio_pkg::audio_mid_t o_out,
	output logic                  o_valid,
	input  logic                  i_ready
);

	audio_pkg::audio_mid_t mixed;

	// Divide by a power of two, sign-aware
	function automatic audio_pkg::sample_t shr(
		input audio_pkg::sample_t v,
		input int unsigned        n,
		input logic               sgn
	);
		if (sgn)
			return audio_pkg::sample_t'($signed(v) >>> n);
		return v >> n;
	endfunction

	// Own channel blended with a share of the opposite one
	function automatic audio_pkg::sample_t mix_chan(
		input audio_pkg::sample_t   own,
		input audio_pkg::sample_t   other,
		input audio_pkg::mix_mode_t mode,
		input logic                 sgn
	);
		case (mode)
			2'd1:    return own - shr(own, 3, sgn) + shr(other, 3, sgn);
			2'd2:    return own - shr(own, 2, sgn) + shr(other, 2, sgn);
			// Even mix, half of each
			2'd3:    return shr(own, 1, sgn) + shr(other, 1, sgn);
			default: return own;
		endcase
	endfunction

	always_comb begin
		mixed.left      = mix_chan(i_in.left, i_in.right, i_in.mix, i_in.is_signed);
		mixed.right     = mix_chan(i_in.right, i_in.left, i_in.mix, i_in.is_signed);
		mixed.is_signed = i_in.is_signed;
	end

	// ====================
	// Output register
	// ====================

	// Free slot, or the slot drains this cycle
	assign o_ready = ~o_valid | i_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			o_valid <= 1'b0;
		else if (o_ready)
			o_valid <= i_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (i_valid && o_ready)
			o_out <= mixed;
	end

endmodule

/* audio_cmd_decoder.sv */
// Host command decoder for volume

`timescale 1ns/1ps

module audio_cmd_decoder #(
	parameter int SHIFT_BITS = 4
) (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_io_uio,
	input  logic                i_io_strobe,
	input  audio_pkg::io_word_t i_io_din,
	output audio_pkg::vol_att_t o_vol_att
);

	logic                  strobe_q;
	logic                  strobe_rise;
	logic                  cmd_load;
	audio_pkg::cmd_state_t state;
	audio_pkg::cmd_code_t  cmd_code;
	audio_pkg::vol_att_t   new_att;

	// A held strobe level counts as one word
	assign strobe_rise = i_io_strobe & ~strobe_q;

	// First word of a frame carries the command code
	assign cmd_load = i_io_uio & strobe_rise & (state != audio_pkg::DATA);

	// Mute flag and shift field straight from the low bits of the word
	always_comb begin
		new_att = '0;
		new_att[audio_pkg::VOL_MUTE_BIT] = i_io_din[audio_pkg::VOL_MUTE_BIT];
		new_att[SHIFT_BITS-1:0] = i_io_din[SHIFT_BITS-1:0];
	end

	// ====================
	// Frame FSM
	// ====================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_q  <= 1'b0;
			state     <= audio_pkg::IDLE;
			o_vol_att <= '0;
		end else begin
			strobe_q <= i_io_strobe;
			if (!i_io_uio) begin
				state <= audio_pkg::IDLE;
			end else begin
				case (state)
					audio_pkg::IDLE: begin
						// Frame just opened, the command word may come at once
						state <= strobe_rise ? audio_pkg::DATA : audio_pkg::WAIT_CMD;
					end
					audio_pkg::WAIT_CMD: begin
						if (strobe_rise)
							state <= audio_pkg::DATA;
					end
					audio_pkg::DATA: begin
						// Data words of other codes fall through untouched
						if (strobe_rise && cmd_code == audio_pkg::CMD_VOLUME)
							o_vol_att <= new_att;
					end
					default: state <= audio_pkg::IDLE;
				endcase
			end
		end
	end

	// Command code, low byte of the first word
	always_ff @(posedge clk_sys) begin
		if (cmd_load)
			cmd_code <= i_io_din[7:0];
	end

endmodule

/* audio_pkg.sv */
// Audio post-processing shared types

package audio_pkg;

	// ====================
	// Widths
	// ====================

	// Bit position of the mute flag in the attenuation word
	localparam int VOL_MUTE_BIT = 4;

	typedef logic [15:0] sample_t;
	typedef logic [1:0]  mix_mode_t;
	typedef logic [VOL_MUTE_BIT:0] vol_att_t;
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_code_t;

	// Host command codes, only volume is handled here
	localparam cmd_code_t CMD_VOLUME = 8'h26;

	// ====================
	// Sample records
	// ====================

	// Stereo sample as it enters the path
	typedef struct packed {
		sample_t   left;
		sample_t   right;
		logic      is_signed;
		mix_mode_t mix;
	} audio_in_t;

	// Between crossfeed, volume and format
	typedef struct packed {
		sample_t left;
		sample_t right;
		logic    is_signed;
	} audio_mid_t;

	// PCM words for serial transmitters, offset-binary words for the DAC
	typedef struct packed {
		sample_t pcm_l;
		sample_t pcm_r;
		sample_t dac_l;
		sample_t dac_r;
	} audio_out_t;

	// Command frame tracking
	typedef enum logic [1:0] {
		IDLE,
		WAIT_CMD,
		DATA
	} cmd_state_t;

endpackage
